// ==== logic/mmioTypesPkg.sv ====
// Bus, width and shell side struct types of the MMIO client
`default_nettype none

package mmioTypesPkg;

  // ========================================
  // Plain widths
  // ========================================
  typedef logic [7:0]  emifAddr_t;    // Full EMIF byte address
  typedef logic [7:0]  emifData_t;    // One data byte on the bus
  typedef logic [6:0]  regOffset_t;   // Low 7 address bits, offset in a page
  typedef logic [3:0]  pageSel_t;     // 16 RAM pages
  typedef logic [$bits(pageSel_t)+$bits(regOffset_t)-1:0] ramAddr_t;  // {page, offset}
  typedef logic [47:0] macAddr_t;
  typedef logic [31:0] ipAddr_t;

  // ========================================
  // Grouped signals
  // ========================================
  typedef struct packed {
    logic      csN;     // Chip select, active low
    logic      weN;     // Low for a write
    logic      oeN;     // Low lets a read drive the bus
    emifAddr_t addr;
    emifData_t data;    // Write data from the host
  } emifReq_t;

  // Status coming back from the shell
  typedef struct packed {
    logic mc0InitCalComplete;
    logic mc1InitCalComplete;
    logic ethCoreReady;
    logic qpllLock;
  } shellStatus_t;

  typedef struct packed {
    logic     rxEqualizerMode;
    logic     pcsLoopbackEn;
    logic     macLoopbackEn;
    macAddr_t macAddress;
    ipAddr_t  ipAddress;
  } shellCtrl_t;

endpackage

`default_nettype wire

// ==== logic/mmioMapPkg.sv ====
// Register offsets, reset values and page RAM geometry
`default_nettype none

package mmioMapPkg;

  import mmioTypesPkg::*;

  // ========================================
  // Register offsets
  // ========================================
  // Configuration, read only
  localparam regOffset_t CfgVpd       = 7'h00;
  localparam regOffset_t CfgVer       = 7'h01;
  localparam regOffset_t CfgRev       = 7'h02;
  // Physical
  localparam regOffset_t PhyStat      = 7'h10;  // Read only, shell status
  localparam regOffset_t PhyCtrl      = 7'h11;
  // Layer 2
  localparam regOffset_t Ly2Ctrl      = 7'h20;
  localparam regOffset_t Ly2Mac0      = 7'h22;  // Most significant MAC byte
  localparam regOffset_t Ly2Mac1      = 7'h23;
  localparam regOffset_t Ly2Mac2      = 7'h24;
  localparam regOffset_t Ly2Mac3      = 7'h25;
  localparam regOffset_t Ly2Mac4      = 7'h26;
  localparam regOffset_t Ly2Mac5      = 7'h27;
  // Layer 3
  localparam regOffset_t Ly3Ctrl0     = 7'h30;
  localparam regOffset_t Ly3Ip0       = 7'h34;  // Most significant IP byte
  localparam regOffset_t Ly3Ip1       = 7'h35;
  localparam regOffset_t Ly3Ip2       = 7'h36;
  localparam regOffset_t Ly3Ip3       = 7'h37;
  // Diagnostic
  localparam regOffset_t DiagScratch0 = 7'h70;
  localparam regOffset_t DiagScratch1 = 7'h71;
  localparam regOffset_t DiagScratch2 = 7'h72;
  localparam regOffset_t DiagScratch3 = 7'h73;
  localparam regOffset_t DiagLoopCtrl = 7'h74;
  localparam regOffset_t DiagPageSel  = 7'h7F;  // Low nibble picks the RAM page

  // ========================================
  // Reset values
  // ========================================
  localparam emifData_t cVpdValue       = 8'h3C;  // User product data
  localparam emifData_t cVersion        = 8'h01;
  localparam emifData_t cRevision       = 8'h00;
  localparam emifData_t cPhyCtrlDefault = 8'h01;  // Rx equalizer mode on
  localparam emifData_t cRegDefault     = 8'h00;  // Every other writable byte

  // Page RAM geometry
  localparam int cRamPages = 16;
  localparam int cPageBytes = 128;
  localparam int cRamBytes = cRamPages * cPageBytes;  // 2 KB

endpackage

`default_nettype wire

// ==== logic/emifDecoder.sv ====
// EMIF access decoder: region split, write strobes and read data return
`timescale 1ns/1ps
`default_nettype none

module emifDecoder
(
  input  wire                          shlClk,
  input  wire                          reset,
  input  wire mmioTypesPkg::emifReq_t  emifReq,
  input  wire mmioTypesPkg::emifData_t regRdData,  // From register file, registered
  input  wire mmioTypesPkg::emifData_t ramRdData,  // From page RAM, registered
  output logic                         regWr,
  output logic                         ramEn,
  output logic                         ramWr,
  output mmioTypesPkg::regOffset_t     offset,
  output mmioTypesPkg::emifData_t      wrData,
  output mmioTypesPkg::emifData_t      rdData,
  output logic                         dataOe
);

  import mmioTypesPkg::*;

  logic access;      // Chip selected this cycle
  logic upperWin;    // Address bit 7, page window
  logic rdFromRam;   // Region of the last read

  // ========================================
  // Access decode
  // ========================================
  assign access   = ~emifReq.csN;
  assign upperWin = emifReq.addr[$bits(emifAddr_t)-1];
  assign offset   = emifReq.addr[$bits(regOffset_t)-1:0];  // Shared by both regions
  assign wrData   = emifReq.data;

  // Register space only below 0x80
  assign regWr = access & ~emifReq.weN & ~upperWin;
  assign ramEn = access & upperWin;         // Read or write into the window
  assign ramWr = ramEn & ~emifReq.weN;

  // ========================================
  // Read return, one cycle behind the access
  // ========================================
  always_ff @(posedge shlClk)
  begin
    if (reset)
    begin
      rdFromRam <= 1'b0;
      dataOe    <= 1'b0;
    end
    else
    begin
      // Drive the bus only after a read with oeN low
      dataOe <= access & emifReq.weN & ~emifReq.oeN;
      if (access & emifReq.weN)
      begin
        rdFromRam <= upperWin;  // Steers the mux next cycle
      end
    end
  end

  // Both sources already carry one cycle of latency
  assign rdData = rdFromRam ? ramRdData : regRdData;

endmodule

`default_nettype wire

// ==== logic/mmioRegFile.sv ====
// Control and status register file with write decode, read mux and shell outputs
`timescale 1ns/1ps
`default_nettype none

module mmioRegFile
(
  input  wire                             shlClk,
  input  wire                             reset,
  input  wire                             regWr,       // One cycle write strobe
  input  wire mmioTypesPkg::regOffset_t   offset,
  input  wire mmioTypesPkg::emifData_t    wrData,
  input  wire mmioTypesPkg::shellStatus_t shellStatus,
  output mmioTypesPkg::emifData_t         regRdData,
  output mmioTypesPkg::shellCtrl_t        shellCtrl,
  output mmioTypesPkg::pageSel_t          pageSel
);

  import mmioTypesPkg::*;
  import mmioMapPkg::*;

  // ========================================
  // Register storage
  // ========================================
  emifData_t phyCtrl;
  emifData_t ly2Ctrl;
  emifData_t ly3Ctrl0;
  emifData_t loopCtrl;        // Bit 0 PCS, bit 1 MAC loopback
  emifData_t pageSelReg;
  emifData_t macReg [6];      // Mac0 first
  emifData_t ipReg [4];       // Ip0 first
  emifData_t scratchReg [4];

  // Index within each byte group
  logic [2:0] macIdx;
  logic [1:0] ipIdx;
  logic [1:0] scratchIdx;

  assign macIdx     = 3'(offset - Ly2Mac0);
  assign ipIdx      = 2'(offset - Ly3Ip0);
  assign scratchIdx = 2'(offset - DiagScratch0);

  // Write decode, read-only and unmapped offsets fall through
  always_ff @(posedge shlClk)
  begin
    if (reset)
    begin
      phyCtrl    <= cPhyCtrlDefault;
      ly2Ctrl    <= cRegDefault;
      ly3Ctrl0   <= cRegDefault;
      loopCtrl   <= cRegDefault;
      pageSelReg <= cRegDefault;
      macReg     <= '{default: cRegDefault};
      ipReg      <= '{default: cRegDefault};
      scratchReg <= '{default: cRegDefault};
    end
    else if (regWr)
    begin
      case (offset)
        PhyCtrl:      phyCtrl <= wrData;
        Ly2Ctrl:      ly2Ctrl <= wrData;
        Ly2Mac0, Ly2Mac1, Ly2Mac2, Ly2Mac3, Ly2Mac4, Ly2Mac5:
          macReg[macIdx] <= wrData;
        Ly3Ctrl0:     ly3Ctrl0 <= wrData;
        Ly3Ip0, Ly3Ip1, Ly3Ip2, Ly3Ip3:
          ipReg[ipIdx] <= wrData;
        DiagScratch0, DiagScratch1, DiagScratch2, DiagScratch3:
          scratchReg[scratchIdx] <= wrData;
        DiagLoopCtrl: loopCtrl <= wrData;
        DiagPageSel:  pageSelReg <= wrData;
        default:      ;  // CFG, PhyStat and holes
      endcase
    end
  end

  // ========================================
  // Read mux, registered for one cycle latency
  // ========================================
  always_ff @(posedge shlClk)
  begin
    case (offset)
      CfgVpd:   regRdData <= cVpdValue;
      CfgVer:   regRdData <= cVersion;
      CfgRev:   regRdData <= cRevision;
      PhyStat:  regRdData <= {4'b0000,
                              shellStatus.qpllLock,
                              shellStatus.ethCoreReady,
                              shellStatus.mc1InitCalComplete,
                              shellStatus.mc0InitCalComplete};  // Bit 0 is mc0
      PhyCtrl:  regRdData <= phyCtrl;
      Ly2Ctrl:  regRdData <= ly2Ctrl;
      Ly2Mac0, Ly2Mac1, Ly2Mac2, Ly2Mac3, Ly2Mac4, Ly2Mac5:
        regRdData <= macReg[macIdx];
      Ly3Ctrl0: regRdData <= ly3Ctrl0;
      Ly3Ip0, Ly3Ip1, Ly3Ip2, Ly3Ip3:
        regRdData <= ipReg[ipIdx];
      DiagScratch0, DiagScratch1, DiagScratch2, DiagScratch3:
        regRdData <= scratchReg[scratchIdx];
      DiagLoopCtrl: regRdData <= loopCtrl;
      DiagPageSel:  regRdData <= pageSelReg;
      default:      regRdData <= '0;  // Unmapped reads as zero
    endcase
  end

  // ========================================
  // Shell outputs
  // ========================================
  always_comb
  begin
    shellCtrl.rxEqualizerMode = phyCtrl[0];
    shellCtrl.pcsLoopbackEn   = loopCtrl[0];
    shellCtrl.macLoopbackEn   = loopCtrl[1];
    shellCtrl.macAddress      = {macReg[0], macReg[1], macReg[2],
                                 macReg[3], macReg[4], macReg[5]};
    shellCtrl.ipAddress       = {ipReg[0], ipReg[1], ipReg[2], ipReg[3]};
  end

  assign pageSel = pageSelReg[$bits(pageSel_t)-1:0];  // Upper bits alias

endmodule

`default_nettype wire

// ==== logic/pageRam.sv ====
// Paged 2 KB single-port byte RAM behind the upper address window
`timescale 1ns/1ps
`default_nettype none

module pageRam
(
  input  wire                           shlClk,
  input  wire                           ramEn,
  input  wire                           ramWr,
  input  wire mmioTypesPkg::pageSel_t   pageSel,  // From the page select register
  input  wire mmioTypesPkg::regOffset_t offset,
  input  wire mmioTypesPkg::emifData_t  wrData,
  output mmioTypesPkg::emifData_t       ramRdData
);

  import mmioTypesPkg::*;
  import mmioMapPkg::*;

  emifData_t mem [cRamBytes];  // Contents undefined until written
  ramAddr_t  ramAddr;

  assign ramAddr = {pageSel, offset};  // Page is the upper part

  // Write on enable and write, otherwise synchronous read
  always_ff @(posedge shlClk)
  begin
    if (ramEn)
    begin
      if (ramWr)
      begin
        mem[ramAddr] <= wrData;
      end
      else
      begin
        ramRdData <= mem[ramAddr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/mmioClient.sv ====
// MMIO client top: EMIF decoder, register file and page RAM
`timescale 1ns/1ps
`default_nettype none

module mmioClient
(
  input  wire                             shlClk,       // Shell clock, bus sampled on it
  input  wire                             reset,
  input  wire mmioTypesPkg::emifReq_t     emifReq,
  input  wire mmioTypesPkg::shellStatus_t shellStatus,
  output wire mmioTypesPkg::emifData_t    rdData,
  output wire                             dataOe,       // Bus drive enable
  output wire mmioTypesPkg::shellCtrl_t   shellCtrl
);

  import mmioTypesPkg::*;

  // ========================================
  // Internal nets
  // ========================================
  logic       regWr;
  logic       ramEn;
  logic       ramWr;
  regOffset_t offset;      // Shared by both regions
  emifData_t  wrData;
  emifData_t  regRdData;
  emifData_t  ramRdData;
  pageSel_t   pageSel;

  // Bus front end
  emifDecoder emifDecoder_inst
  (
    .shlClk    (shlClk),
    .reset     (reset),
    .emifReq   (emifReq),
    .regRdData (regRdData),
    .ramRdData (ramRdData),
    .regWr     (regWr),
    .ramEn     (ramEn),
    .ramWr     (ramWr),
    .offset    (offset),
    .wrData    (wrData),
    .rdData    (rdData),
    .dataOe    (dataOe)
  );

  mmioRegFile mmioRegFile_inst
  (
    .shlClk      (shlClk),
    .reset       (reset),
    .regWr       (regWr),
    .offset      (offset),
    .wrData      (wrData),
    .shellStatus (shellStatus),
    .regRdData   (regRdData),
    .shellCtrl   (shellCtrl),
    .pageSel     (pageSel)
  );

  // Upper window, page from the register file
  pageRam pageRam_inst
  (
    .shlClk    (shlClk),
    .ramEn     (ramEn),
    .ramWr     (ramWr),
    .pageSel   (pageSel),
    .offset    (offset),
    .wrData    (wrData),
    .ramRdData (ramRdData)
  );

endmodule

`default_nettype wire

// ==== dv/mmioClientTb.sv ====
// Testbench with clock, reset, bus tasks, reference model and checks for the MMIO client
`timescale 1ns/1ps
`default_nettype none

module mmioClientTb;

  import mmioTypesPkg::*;
  import mmioMapPkg::*;

  logic         shlClk;
  logic         reset;
  emifReq_t     emifReq;
  shellStatus_t shellStatus;
  emifData_t    rdData;
  logic         dataOe;
  shellCtrl_t   shellCtrl;

  // Reference model of the map and the page RAM
  emifData_t   regModel [128];
  emifData_t   ramModel [cRamBytes];   // X until written
  ramAddr_t    ramWritten [$];         // Locations with known contents
  logic        pendChk;                // Read issued in the previous cycle
  emifData_t   pendExp;
  logic [31:0] rngState;
  int          checks;
  int          errors;
  int          oeErrors;
  logic        oeRead;

  mmioClient mmioClient_inst
  (
    .shlClk      (shlClk),
    .reset       (reset),
    .emifReq     (emifReq),
    .shellStatus (shellStatus),
    .rdData      (rdData),
    .dataOe      (dataOe),
    .shellCtrl   (shellCtrl)
  );

  initial
  begin
    shlClk = 1'b0;
    forever #2 shlClk = ~shlClk;  // 4 ns period
  end

  // ========================================
  // Output enable one cycle behind the read
  // ========================================
  assign oeRead = ~emifReq.csN & emifReq.weN & ~emifReq.oeN;

  oeAfterRead: assert property (@(posedge shlClk) disable iff (reset) oeRead |=> dataOe)
  else
  begin
    oeErrors++;
    $display("** Error at %0t ns: dataOe expected 1, got %b", $time, $sampled(dataOe));
  end

  oeLowOtherwise: assert property (@(posedge shlClk) disable iff (reset) !oeRead |=> !dataOe)
  else
  begin
    oeErrors++;
    $display("** Error at %0t ns: dataOe expected 0, got %b", $time, $sampled(dataOe));
  end

  // ========================================
  // Model helpers
  // ========================================
  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);  // 32-bit xorshift
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic isWritable(regOffset_t off);
    case (off)
      PhyCtrl, Ly2Ctrl, Ly3Ctrl0, DiagLoopCtrl, DiagPageSel: return 1'b1;
      Ly2Mac0, Ly2Mac1, Ly2Mac2, Ly2Mac3, Ly2Mac4, Ly2Mac5: return 1'b1;
      Ly3Ip0, Ly3Ip1, Ly3Ip2, Ly3Ip3: return 1'b1;
      DiagScratch0, DiagScratch1, DiagScratch2, DiagScratch3: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic emifData_t modelRead(emifAddr_t addr);
    regOffset_t off;
    emifData_t  stat;
    off = addr[6:0];
    stat = 8'h00;  // Upper nibble stays zero
    if (addr[7])
      return ramModel[{regModel[DiagPageSel][3:0], off}];  // Low nibble is the page
    case (off)
      CfgVpd:  return cVpdValue;
      CfgVer:  return cVersion;
      CfgRev:  return cRevision;
      PhyStat:
      begin
        stat[0] = shellStatus.mc0InitCalComplete;  // Bits 0 to 3 in struct order
        stat[1] = shellStatus.mc1InitCalComplete;
        stat[2] = shellStatus.ethCoreReady;
        stat[3] = shellStatus.qpllLock;
        return stat;
      end
      default: return isWritable(off) ? regModel[off] : 8'h00;  // Holes read zero
    endcase
  endfunction

  function automatic emifAddr_t regAddr(regOffset_t off);
    return {1'b0, off};
  endfunction

  function automatic emifAddr_t winAddr(regOffset_t off);
    return {1'b1, off};
  endfunction

  task automatic checkValue(input string name, input logic [47:0] expVal,
                            input logic [47:0] actVal);
    checks++;
    assert (actVal === expVal)
    else
    begin
      errors++;
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expVal, actVal);
    end
  endtask

  // ========================================
  // Bus tasks driving inputs on the falling edge
  // ========================================
  task automatic busCycle(input logic csN, input logic weN, input logic oeN,
                          input emifAddr_t addr, input emifData_t data);
    @(negedge shlClk);
    if (pendChk)
      checkValue("rdData", 48'(pendExp), 48'(rdData));  // Read from one cycle back
    pendChk = ~csN & weN;
    pendExp = modelRead(addr);
    if (~csN & ~weN)
    begin
      if (addr[7])
      begin
        ramModel[{regModel[DiagPageSel][3:0], addr[6:0]}] = data;
        ramWritten.push_back({regModel[DiagPageSel][3:0], addr[6:0]});
      end
      else if (isWritable(addr[6:0]))
        regModel[addr[6:0]] = data;
    end
    emifReq.csN  = csN;
    emifReq.weN  = weN;
    emifReq.oeN  = oeN;
    emifReq.addr = addr;
    emifReq.data = data;
  endtask

  task automatic busWrite(input emifAddr_t addr, input emifData_t data);
    busCycle(1'b0, 1'b0, 1'b1, addr, data);
  endtask

  task automatic busRead(input emifAddr_t addr, input logic oeN);
    busCycle(1'b0, 1'b1, oeN, addr, emifData_t'(nextRand()));
  endtask

  task automatic busIdle();
    busCycle(1'b1, 1'b1, 1'b1, 8'h00, 8'h00);
  endtask

  task automatic checkShell();
    checkValue("rxEqualizerMode", 48'(regModel[PhyCtrl][0]), 48'(shellCtrl.rxEqualizerMode));
    checkValue("pcsLoopbackEn", 48'(regModel[DiagLoopCtrl][0]), 48'(shellCtrl.pcsLoopbackEn));
    checkValue("macLoopbackEn", 48'(regModel[DiagLoopCtrl][1]), 48'(shellCtrl.macLoopbackEn));
    checkValue("macAddress", {regModel[Ly2Mac0], regModel[Ly2Mac1], regModel[Ly2Mac2],
                              regModel[Ly2Mac3], regModel[Ly2Mac4], regModel[Ly2Mac5]},
               shellCtrl.macAddress);
    checkValue("ipAddress", 48'({regModel[Ly3Ip0], regModel[Ly3Ip1], regModel[Ly3Ip2],
                                 regModel[Ly3Ip3]}), 48'(shellCtrl.ipAddress));
  endtask

  // ========================================
  // Test sequence
  // ========================================
  task automatic runTests();
    regOffset_t roList [7] = '{CfgVpd, CfgVer, CfgRev, PhyStat, 7'h45, 7'h7E, 7'h21};
    regOffset_t ctrlList [5] = '{PhyCtrl, Ly2Ctrl, Ly3Ctrl0, DiagLoopCtrl, DiagPageSel};
    ramAddr_t   loc;
    checkValue("dataOe", 48'(1'b0), 48'(dataOe));
    checkShell();
    busRead(regAddr(CfgVpd), 1'b0);
    busRead(regAddr(CfgVer), 1'b0);
    busRead(regAddr(CfgRev), 1'b0);
    busRead(regAddr(PhyCtrl), 1'b0);

    // Status bits and read-only protection
    repeat (6)
    begin
      busIdle();
      shellStatus = 4'(nextRand());
      busRead(regAddr(PhyStat), 1'b0);
    end
    foreach (roList[i])
    begin
      busWrite(regAddr(roList[i]), emifData_t'(nextRand()));
      busRead(regAddr(roList[i]), 1'b0);  // Write then read back to back
    end

    // Control bytes onto the shell outputs
    repeat (3)
    begin
      for (int i = 0; i < 6; i++)
        busWrite(regAddr(regOffset_t'(Ly2Mac0 + i)), emifData_t'(nextRand()));
      for (int i = 0; i < 4; i++)
        busWrite(regAddr(regOffset_t'(Ly3Ip0 + i)), emifData_t'(nextRand()));
      busWrite(regAddr(PhyCtrl), emifData_t'(nextRand()));
      busWrite(regAddr(DiagLoopCtrl), emifData_t'(nextRand()));
      busIdle();
      checkShell();
    end
    for (int i = 0; i < 4; i++)
      busWrite(regAddr(regOffset_t'(DiagScratch0 + i)), emifData_t'(nextRand()));
    for (int i = 0; i < 4; i++)
      busRead(regAddr(regOffset_t'(DiagScratch0 + i)), 1'b0);

    // Stored control bytes read back
    foreach (ctrlList[i])
    begin
      busWrite(regAddr(ctrlList[i]), emifData_t'(nextRand()));
      busRead(regAddr(ctrlList[i]), 1'b0);
    end

    // Page RAM through the upper window
    repeat (24)
    begin
      busWrite(regAddr(DiagPageSel), emifData_t'(nextRand()));  // Upper bits random
      busWrite(winAddr(7'(nextRand())), emifData_t'(nextRand()));
    end
    busWrite(regAddr(DiagPageSel), 8'h13);  // Aliases to page 3
    busWrite(winAddr(7'h05), emifData_t'(nextRand()));
    busWrite(regAddr(DiagPageSel), 8'h03);
    busRead(winAddr(7'h05), 1'b0);
    foreach (ramWritten[i])
    begin
      loc = ramWritten[i];
      busWrite(regAddr(DiagPageSel), {4'(nextRand()), loc[10:7]});
      busRead(winAddr(loc[6:0]), 1'(nextRand()));
    end
    for (int i = 0; i < 4; i++)
      busRead(regAddr(regOffset_t'(DiagScratch0 + i)), 1'b0);
    for (int i = 0; i < 6; i++)
      busRead(regAddr(regOffset_t'(Ly2Mac0 + i)), 1'b0);
    busIdle();
    checkShell();

    // Back-to-back reads alternating regions with random oeN
    busWrite(regAddr(DiagPageSel), 8'h03);
    for (int i = 0; i < 16; i++)
      busWrite(winAddr(7'(i)), emifData_t'(nextRand()));
    repeat (16)
    begin
      busRead(regAddr(7'(nextRand())), 1'(nextRand()));
      busRead(winAddr(7'(nextRand() & 32'h0F)), 1'(nextRand()));
    end
    busIdle();
    busIdle();
  endtask

  initial
  begin
    reset       = 1'b1;
    emifReq     = '{csN: 1'b1, weN: 1'b1, oeN: 1'b1, addr: '0, data: '0};
    shellStatus = '0;
    pendChk     = 1'b0;
    pendExp     = '0;
    rngState    = 32'd24110;
    checks      = 0;
    errors      = 0;
    oeErrors    = 0;
    regModel    = '{default: 8'h00};
    regModel[PhyCtrl] = cPhyCtrlDefault;
    repeat (2) @(posedge shlClk);
    @(negedge shlClk);
    reset = 1'b0;
    runTests();
    $display("Checks: %0d, value errors: %0d, dataOe errors: %0d", checks, errors, oeErrors);
    if (errors == 0 && oeErrors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
logic/mmioTypesPkg.sv
logic/mmioMapPkg.sv
logic/emifDecoder.sv
logic/mmioRegFile.sv
logic/pageRam.sv
logic/mmioClient.sv
dv/mmioClientTb.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= mmioClientTb
FILELIST ?= src.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJDIR) $(LOG)
